// ==== hdl/i2s_settings.svh ====
/* Fixed I2S word format for the codec endpoint. Only 16-bit samples are handled.
   The counter width must hold one count more than the sample width. */
`ifndef I2S_SETTINGS_SVH
`define I2S_SETTINGS_SVH

// Bits per audio sample, MSB first on the wire
`define I2S_SAMPLE_W 16

// BCLK rise counter per half frame
// Must cover the delay bit, the sample bits and the latch slot
`define I2S_CNT_W 5

`endif

// ==== hdl/i2s_pkg.sv ====
/* Shared types of the I2S codec endpoint. The sample width comes from the
   settings header, so there are no package parameters. */
`include "i2s_settings.svh"

package i2s_pkg;

  // One audio sample
  // Two's complement on the wire, but the design only moves raw bits
  typedef logic [`I2S_SAMPLE_W-1:0] sample_t;

  // Channel picked by the LRCLK level in standard I2S
  typedef enum logic {
    CH_LEFT  = 1'b0,  // LRCLK low
    CH_RIGHT = 1'b1   // LRCLK high
  } channel_e;

endpackage

// ==== hdl/i2s_edge_if.sv ====
/* Edge strobes of BCLK and LRCLK in the clk_i domain. Each strobe is high
   for one cycle, and lrclk_lvl is the registered LRCLK level. */
`timescale 1ns/100ps

interface i2s_edge_if ();

  logic bclk_rise;   // BCLK went 0 -> 1
  logic bclk_fall;   // BCLK went 1 -> 0
  logic lrclk_rise;  // Start of right half frame
  logic lrclk_fall;  // Start of left half frame
  logic lrclk_lvl;   // Registered LRCLK, updated with the strobes

  modport det (
    output bclk_rise, bclk_fall, lrclk_rise, lrclk_fall, lrclk_lvl
  );

  // Receiver samples DAC data on BCLK rise
  modport rx (
    input bclk_rise, lrclk_rise, lrclk_fall, lrclk_lvl
  );

  // Transmitter changes ADC data on BCLK fall
  modport tx (
    input bclk_fall, lrclk_rise, lrclk_fall, lrclk_lvl
  );

endinterface

// ==== hdl/i2s_edge_detect.sv ====
/* BCLK and LRCLK are sampled directly, with no synchronizer. Both must be
   clean levels that stay stable for several clk_i cycles. */
`timescale 1ns/100ps

module i2s_edge_detect (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      bclk,
  input  logic      lrclk,
  i2s_edge_if.det   edges
);

  logic bclk_q;   // BCLK as seen at the last clock edge
  logic lrclk_q;  // LRCLK as seen at the last clock edge

  // Bit clock edges
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bclk_q          <= 1'b0;
      edges.bclk_rise <= 1'b0;
      edges.bclk_fall <= 1'b0;
    end else begin
      bclk_q          <= bclk;
      edges.bclk_rise <= bclk & ~bclk_q;
      edges.bclk_fall <= ~bclk & bclk_q;
    end
  end

  // Word select edges
  // The strobe and the new level show up in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lrclk_q          <= 1'b0;
      edges.lrclk_rise <= 1'b0;
      edges.lrclk_fall <= 1'b0;
    end else begin
      lrclk_q          <= lrclk;
      edges.lrclk_rise <= lrclk & ~lrclk_q;  // Right half starts
      edges.lrclk_fall <= ~lrclk & lrclk_q;  // Left half starts
    end
  end

  // Downstream blocks use this and never the raw pin
  assign edges.lrclk_lvl = lrclk_q;

endmodule

// ==== hdl/i2s_rx_deserializer.sv ====
/* Standard I2S receive with one BCLK of delay after each LRCLK edge. A half
   frame needs at least 18 BCLK periods, or the word is never latched. */
`timescale 1ns/100ps
`include "i2s_settings.svh"

module i2s_rx_deserializer (
  input  logic             clk_i,
  input  logic             rst_ni,
  i2s_edge_if.rx           edges,
  input  logic             dac_sdata,
  output i2s_pkg::sample_t rx_left,
  output i2s_pkg::sample_t rx_right
);
  import i2s_pkg::*;

  localparam logic [`I2S_CNT_W-1:0] FIRST_BIT = `I2S_CNT_W'(1);  // Count 0 is the delay bit
  localparam logic [`I2S_CNT_W-1:0] LAST_BIT  = `I2S_CNT_W'(`I2S_SAMPLE_W);
  localparam logic [`I2S_CNT_W-1:0] CNT_MAX   = '1;

  logic [`I2S_CNT_W-1:0] bit_cnt_q;  // BCLK rises since the last LRCLK edge
  sample_t               shift_q;
  logic                  frame_edge;
  logic                  in_word;
  logic                  past_word;
  channel_e              channel;

  assign frame_edge = edges.lrclk_rise | edges.lrclk_fall;
  assign channel    = channel_e'(edges.lrclk_lvl);

  // Decoded from the count before it increments
  assign in_word   = (bit_cnt_q >= FIRST_BIT) && (bit_cnt_q <= LAST_BIT);
  assign past_word = bit_cnt_q > LAST_BIT;

  // Holds at the top so a long half frame does not wrap into the data slots
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
    end else if (frame_edge) begin
      bit_cnt_q <= '0;
    end else if (edges.bclk_rise && (bit_cnt_q != CNT_MAX)) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  // Shift in MSB first, then hand the word to the current channel
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q  <= '0;
      rx_left  <= '0;
      rx_right <= '0;
    end else if (frame_edge) begin
      shift_q <= '0;
    end else if (edges.bclk_rise) begin
      if (in_word) begin
        shift_q <= {shift_q[`I2S_SAMPLE_W-2:0], dac_sdata};
      end else if (past_word) begin
        // Copied on every later rise, the word no longer changes
        case (channel)
          CH_LEFT:  rx_left  <= shift_q;
          CH_RIGHT: rx_right <= shift_q;
          default:  rx_left  <= shift_q;
        endcase
      end
    end
  end

endmodule

// ==== hdl/i2s_tx_serializer.sv ====
/* Standard I2S transmit. The sample of a channel is taken only at the LRCLK
   edge that starts its half frame; later changes wait for the next one. */
`timescale 1ns/100ps

module i2s_tx_serializer (
  input  logic             clk_i,
  input  logic             rst_ni,
  i2s_edge_if.tx           edges,
  input  i2s_pkg::sample_t tx_left,
  input  i2s_pkg::sample_t tx_right,
  output logic             adc_sdata
);
  import i2s_pkg::*;

  // Delay bit on top of the sample
  localparam int unsigned REG_W = $bits(sample_t) + 1;

  logic [REG_W-1:0] shift_q;
  logic             frame_edge;
  channel_e         channel;
  sample_t          next_sample;

  assign frame_edge = edges.lrclk_rise | edges.lrclk_fall;

  // lrclk_lvl already holds the level after the edge
  assign channel = channel_e'(edges.lrclk_lvl);

  always_comb begin
    case (channel)
      CH_LEFT:  next_sample = tx_left;
      CH_RIGHT: next_sample = tx_right;
      default:  next_sample = tx_left;
    endcase
  end

  // Load on LRCLK edge, shift on BCLK fall
  // The load wins when both strobes land in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q <= '0;
    end else if (frame_edge) begin
      shift_q <= {1'b0, next_sample};
    end else if (edges.bclk_fall) begin
      shift_q <= {shift_q[REG_W-2:0], 1'b0};  // Zero fill after the LSB
    end
  end

  assign adc_sdata = shift_q[REG_W-1];

endmodule

// ==== hdl/i2s_codec_endpoint.sv ====
/* Codec side of an I2S link, stereo, 16-bit standard format, all in clk_i.
   ac_mclk is accepted for pin compatibility and not used. BCLK and LRCLK
   must be slow, clean levels relative to clk_i. */
`timescale 1ns/100ps

module i2s_codec_endpoint (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             ac_mclk,       // Codec master clock, unused
  input  logic             ac_bclk,       // Bit clock from the controller
  input  logic             ac_lrclk,      // Word select, low is left
  input  logic             ac_dac_sdata,  // Playback data from the controller
  output logic             ac_adc_sdata,  // Record data to the controller
  input  i2s_pkg::sample_t tx_left,
  input  i2s_pkg::sample_t tx_right,
  output i2s_pkg::sample_t rx_left,
  output i2s_pkg::sample_t rx_right
);

  i2s_edge_if edges ();

  // Clock edges to one-cycle strobes
  i2s_edge_detect u_edge_detect (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bclk   (ac_bclk),
    .lrclk  (ac_lrclk),
    .edges  (edges.det)
  );

  // Playback path
  i2s_rx_deserializer u_rx (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .edges     (edges.rx),
    .dac_sdata (ac_dac_sdata),
    .rx_left   (rx_left),
    .rx_right  (rx_right)
  );

  // Record path
  i2s_tx_serializer u_tx (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .edges     (edges.tx),
    .tx_left   (tx_left),
    .tx_right  (tx_right),
    .adc_sdata (ac_adc_sdata)
  );

endmodule

// ==== bench/i2s_codec_properties.sv ====
/* Checks on the edge strobes and the ADC serial output of the codec endpoint.
   Bound into the top level, failures are counted for the testbench. */
`timescale 1ns/100ps

module i2s_codec_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic bclk_rise,
  input logic bclk_fall,
  input logic lrclk_rise,
  input logic lrclk_fall,
  input logic adc_sdata
);

  int unsigned fail_cnt = 0;

  // Rise and fall of one clock never together
  a_bclk_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bclk_rise && bclk_fall))
    else begin $error("BCLK rise and fall strobes high together"); fail_cnt++; end

  a_lrclk_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(lrclk_rise && lrclk_fall))
    else begin $error("LRCLK rise and fall strobes high together"); fail_cnt++; end

  // Strobes last one cycle
  a_bclk_rise_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_rise |=> !bclk_rise)
    else begin $error("BCLK rise strobe longer than one cycle"); fail_cnt++; end

  a_bclk_fall_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_fall |=> !bclk_fall)
    else begin $error("BCLK fall strobe longer than one cycle"); fail_cnt++; end

  a_lrclk_rise_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lrclk_rise |=> !lrclk_rise)
    else begin $error("LRCLK rise strobe longer than one cycle"); fail_cnt++; end

  a_lrclk_fall_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lrclk_fall |=> !lrclk_fall)
    else begin $error("LRCLK fall strobe longer than one cycle"); fail_cnt++; end

  // I2S delay bit right after the word select edge
  a_delay_bit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lrclk_rise || lrclk_fall) |=> !adc_sdata)
    else begin $error("ADC data not low after LRCLK edge"); fail_cnt++; end

endmodule

bind i2s_codec_endpoint i2s_codec_properties u_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .bclk_rise  (edges.bclk_rise),
  .bclk_fall  (edges.bclk_fall),
  .lrclk_rise (edges.lrclk_rise),
  .lrclk_fall (edges.lrclk_fall),
  .adc_sdata  (ac_adc_sdata)
);

// ==== bench/tb_i2s_codec_endpoint.sv ====
/* Testbench for the I2S codec endpoint. The controller model runs 32 BCLK periods
   per half frame at 8 clk_i cycles per BCLK level and starts with a right half. */
`timescale 1ns/100ps
`include "i2s_settings.svh"

module tb_i2s_codec_endpoint;
  import i2s_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 10;
  localparam int BCLK_HALF     = 8;   // clk_i cycles per BCLK level
  localparam int BITS_PER_HALF = 32;  // BCLK periods per half frame
  localparam int IDLE_BCLKS    = 4;
  localparam int N_FRAMES      = 40;
  localparam int W             = `I2S_SAMPLE_W;
  localparam int HALF_CYCLES   = 2 * BCLK_HALF * BITS_PER_HALF;
  localparam int RUN_CYCLES    = RESET_CYCLES + 2 * BCLK_HALF * IDLE_BCLKS
                                 + (2 * N_FRAMES + 1) * HALF_CYCLES + 8;
  localparam int TIMEOUT_NS    = 2 * RUN_CYCLES * CLK_PERIOD;

  logic    clk_i;
  logic    rst_ni;
  logic    ac_mclk;
  logic    ac_bclk;
  logic    ac_lrclk;
  logic    ac_dac_sdata;
  logic    ac_adc_sdata;
  sample_t tx_left;
  sample_t tx_right;
  sample_t rx_left;
  sample_t rx_right;

  sample_t last_left;   // Word rx_left must hold
  sample_t last_right;

  // Results waiting for the compare process
  sample_t got_q[$];
  sample_t exp_q[$];
  string   what_q[$];

  i2s_codec_endpoint dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ac_mclk      (ac_mclk),
    .ac_bclk      (ac_bclk),
    .ac_lrclk     (ac_lrclk),
    .ac_dac_sdata (ac_dac_sdata),
    .ac_adc_sdata (ac_adc_sdata),
    .tx_left      (tx_left),
    .tx_right     (tx_right),
    .rx_left      (rx_left),
    .rx_right     (rx_right)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Slots 1 to W after the delay bit carry the low W bits of the word, MSB first
  function automatic sample_t expected_sample(input logic [31:0] word);
    return word[W-1:0];
  endfunction

  task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "sample compare failed");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "bit compare failed");
    end
  endtask

  task automatic queue_result(input sample_t got, input sample_t exp, input string what);
    got_q.push_back(got);
    exp_q.push_back(exp);
    what_q.push_back(what);
  endtask

  // Inputs change a little after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  // BCLK runs with LRCLK held low, so no frame has started yet
  task automatic idle_phase();
    for (int k = 0; k < IDLE_BCLKS; k++) begin
      ac_bclk = 1'b0;
      wait_cycles(BCLK_HALF);
      ac_bclk = 1'b1;
      check_bit(ac_adc_sdata, 1'b0, "ac_adc_sdata before the first LRCLK edge");
      wait_cycles(BCLK_HALF);
    end
    queue_result(rx_left, '0, "rx_left after reset");
    queue_result(rx_right, '0, "rx_right after reset");
  endtask

  // One half frame of the controller: DAC word out, ADC word in
  task automatic send_half(input channel_e ch);
    logic [31:0] word;
    sample_t     tx_edge;
    sample_t     adc_word;
    word     = $urandom();
    tx_edge  = '0;
    adc_word = '0;
    for (int k = 0; k < BITS_PER_HALF; k++) begin
      ac_bclk      = 1'b0;
      ac_dac_sdata = 1'b0;  // Delay bit and padding
      if (k == 0) begin
        ac_lrclk = ch;  // Word select moves with the BCLK fall
        tx_edge  = (ch == CH_LEFT) ? tx_left : tx_right;
      end
      if (k >= 1 && k <= W) begin
        ac_dac_sdata = word[W-k];
      end
      if (k == BITS_PER_HALF / 4) begin
        // Taken by the DUT only at later LRCLK edges
        tx_left  = sample_t'($urandom());
        tx_right = sample_t'($urandom());
      end
      wait_cycles(BCLK_HALF);
      ac_bclk = 1'b1;
      if (k >= 1 && k <= W) begin
        adc_word[W-k] = ac_adc_sdata;  // Controller samples on the rise
      end
      wait_cycles(BCLK_HALF);
    end
    if (ch == CH_LEFT) begin
      last_left = expected_sample(word);
      queue_result(rx_left, last_left, "rx_left");
      queue_result(rx_right, last_right, "rx_right during left half");
      queue_result(adc_word, expected_sample(32'(tx_edge)), "ADC left word");
    end else begin
      last_right = expected_sample(word);
      queue_result(rx_right, last_right, "rx_right");
      queue_result(rx_left, last_left, "rx_left during right half");
      queue_result(adc_word, expected_sample(32'(tx_edge)), "ADC right word");
    end
  endtask

  // Compare process
  always @(negedge clk_i) begin
    while (got_q.size() > 0) begin
      check_sample(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
    end
    if (dut.u_props.fail_cnt != 0) begin
      $display("A bound assertion on the strobes or the ADC data failed");
      $display("Result: FAILED");
      $fatal(1, "assertion failed");
    end
  end

  initial begin
    void'($urandom(32'hc192_9484));
    rst_ni       = 1'b0;
    ac_mclk      = 1'b0;
    ac_bclk      = 1'b0;
    ac_lrclk     = 1'b0;
    ac_dac_sdata = 1'b0;
    tx_left      = sample_t'($urandom());
    tx_right     = sample_t'($urandom());
    last_left    = '0;
    last_right   = '0;
    wait_cycles(RESET_CYCLES);
    rst_ni = 1'b1;
    idle_phase();
    send_half(CH_RIGHT);  // First LRCLK edge is a rise
    for (int f = 0; f < N_FRAMES; f++) begin
      send_half(CH_LEFT);
      send_half(CH_RIGHT);
    end
    wait_cycles(4);
    if (got_q.size() == 0 && dut.u_props.fail_cnt == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Run ended with %0d assertion failures and %0d unchecked results",
               dut.u_props.fail_cnt, got_q.size());
      $display("Result: FAILED");
      $fatal(1, "run failed");
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/i2s_pkg.sv
hdl/i2s_edge_if.sv
hdl/i2s_edge_detect.sv
hdl/i2s_rx_deserializer.sv
hdl/i2s_tx_serializer.sv
hdl/i2s_codec_endpoint.sv
bench/i2s_codec_properties.sv
bench/tb_i2s_codec_endpoint.sv

// ==== Makefile ====
# Verilator build and run of the I2S codec endpoint testbench

TOP  := tb_i2s_codec_endpoint
SRCS := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): $(SRCS) files.f
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

# Pass or fail is taken from the log
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
